// File: build.f
+incdir+test
hw/dma_pkg.sv
hw/dma_engine.sv
hw/txn_fifo.sv
hw/mem_sink.sv
hw/dma_top.sv
test/tb_dma.sv

// File: hw/dma_engine.sv
`timescale 1ns/100ps

module dma_engine import dma_pkg::*;
#(
   parameter int          RFAW         = 5,             // register address width
   parameter logic [31:0] TEST_PATTERN = 32'hc3a5_5a3c  // fill data
)
(
   input  logic        clk,
   input  logic        reset,
   // host register port
   input  logic        mi_en,
   input  logic        mi_we,
   input  logic [19:0] mi_addr,    // byte address
   input  logic [31:0] mi_din,
   output logic [31:0] mi_dout,
   // transaction stream out
   output dma_txn_t    eng_txn,
   output logic        eng_valid,
   input  logic        eng_ready
);

   logic [RFAW-1:0] reg_sel;       // word select
   logic            mi_wr;
   logic            mi_rd;
   logic            cfg_wr;
   logic            src_wr;
   logic            dst_wr;
   logic            count_wr;

   dma_cfg_u        cfg_in;        // incoming config word
   dma_cfg_u        cfg_q;
   logic [31:0]     src_q;
   logic [31:0]     dst_q;
   logic [31:0]     count_q;
   logic [1:0]      status_q;      // [1] error, [0] busy

   logic [31:0]     step;          // bytes per beat
   logic            last_beat;
   logic            expired;
   logic            mis_err;
   logic            beat;

   // ########################################
   // register decode
   // ########################################
   assign reg_sel  = mi_addr[RFAW+1:2];
   assign mi_wr    = mi_en & mi_we;
   assign mi_rd    = mi_en & ~mi_we;

   assign cfg_wr   = mi_wr & (reg_sel == RFAW'(REG_CFG));
   assign src_wr   = mi_wr & (reg_sel == RFAW'(REG_SRC));
   assign dst_wr   = mi_wr & (reg_sel == RFAW'(REG_DST));
   assign count_wr = mi_wr & (reg_sel == RFAW'(REG_COUNT));

   assign cfg_in.raw = mi_din;

   // config keeps only the defined fields
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         cfg_q.raw <= '0;
      else if (cfg_wr)
      begin
         cfg_q.f.zero     <= '0;
         cfg_q.f.message  <= cfg_in.f.message;
         cfg_q.f.ctrlmode <= cfg_in.f.ctrlmode;
         cfg_q.f.datamode <= cfg_in.f.datamode;
         cfg_q.f.write    <= cfg_in.f.write;
         cfg_q.f.enable   <= cfg_in.f.enable;
      end
   end

   // ########################################
   // beat control
   // ########################################
   assign step      = 32'd1 << cfg_q.f.datamode;
   assign expired   = (count_q == 32'd0);
   assign last_beat = (count_q == 32'd1);

   // low address bits vs access size, double never supported
   assign mis_err = ((src_q[0] | dst_q[0]) & (cfg_q.f.datamode != 2'b00)) |
                    ((src_q[1] | dst_q[1]) & cfg_q.f.datamode[1]) |
                    (cfg_q.f.datamode == 2'b11);

   assign eng_valid = cfg_q.f.enable & ~expired & ~mis_err;
   assign beat      = eng_valid & eng_ready;

   // host write wins over the advance
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         src_q   <= '0;
         dst_q   <= '0;
         count_q <= '0;
      end
      else
      begin
         if (src_wr)
            src_q <= mi_din;
         else if (beat)
            src_q <= src_q + step;
         if (dst_wr)
            dst_q <= mi_din;
         else if (beat)
            dst_q <= dst_q + step;
         if (count_wr)
            count_q <= mi_din;
         else if (beat)
            count_q <= count_q - 32'd1;
      end
   end

   // status, cleared by any config write
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         status_q <= '0;
      else if (cfg_wr)
         status_q <= '0;
      else
      begin
         status_q[0] <= eng_valid;                                // busy
         status_q[1] <= status_q[1] | (cfg_q.f.enable & mis_err); // sticky
      end
   end

   // ########################################
   // outgoing beat
   // ########################################
   always_comb
   begin
      eng_txn          = '0;
      eng_txn.write    = cfg_q.f.write;
      eng_txn.datamode = cfg_q.f.datamode;
      eng_txn.ctrlmode = (cfg_q.f.message & last_beat) ? CTRL_MESSAGE : cfg_q.f.ctrlmode;
      eng_txn.dstaddr  = dst_q;
      eng_txn.srcaddr  = src_q;
      eng_txn.data     = TEST_PATTERN;  // fixed fill
   end

   // readback, one cycle after the read strobe
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         mi_dout <= '0;
      else if (mi_rd)
      begin
         case (reg_sel)
            RFAW'(REG_CFG):    mi_dout <= cfg_q.raw;
            RFAW'(REG_STATUS): mi_dout <= {30'd0, status_q};
            RFAW'(REG_SRC):    mi_dout <= src_q;
            RFAW'(REG_DST):    mi_dout <= dst_q;
            RFAW'(REG_COUNT):  mi_dout <= count_q;
            default:           mi_dout <= '0;  // unmapped
         endcase
      end
   end

   // ########################################
   // checks
   // ########################################
   // an offered beat is aligned to its own size, never double
   a_no_valid_on_error: assert property (
      @(posedge clk) disable iff (reset)
      eng_valid |-> (eng_txn.datamode != 2'b11) &&
                    ((eng_txn.dstaddr & ~(32'hffff_ffff << eng_txn.datamode)) == 32'd0) &&
                    ((eng_txn.srcaddr & ~(32'hffff_ffff << eng_txn.datamode)) == 32'd0)
   ) else $error("eng_valid raised with alignment error");

   // stalled beat stays put unless the host reprograms
   a_hold_on_stall: assert property (
      @(posedge clk) disable iff (reset)
      eng_valid && !eng_ready && !mi_wr |=> eng_valid && $stable(eng_txn)
   ) else $error("engine beat changed while stalled");

endmodule

// File: hw/dma_pkg.sv
package dma_pkg;

   // ########################################
   // transaction beat
   // ########################################
   typedef struct packed {
      logic        write;     // 1 = write transaction
      logic [1:0]  datamode;  // 0 byte, 1 half, 2 word, 3 double
      logic [3:0]  ctrlmode;
      logic [31:0] dstaddr;
      logic [31:0] srcaddr;
      logic [31:0] data;
      logic        pad;       // rounds the beat up to 104 bits
   } dma_txn_t;

   // ########################################
   // configuration register
   // ########################################
   typedef struct packed {
      logic [22:0] zero;      // reserved, reads 0
      logic        message;   // tag last beat as message
      logic [3:0]  ctrlmode;
      logic [1:0]  datamode;
      logic        write;
      logic        enable;    // bit 0
   } dma_cfg_fields_t;

   typedef union packed {
      logic [31:0]     raw;   // as seen on the register port
      dma_cfg_fields_t f;     // decoded fields
   } dma_cfg_u;

   // register word offsets, mi_addr bits RFAW+1..2
   localparam logic [4:0] REG_CFG    = 5'd0;
   localparam logic [4:0] REG_STATUS = 5'd1;
   localparam logic [4:0] REG_SRC    = 5'd2;
   localparam logic [4:0] REG_DST    = 5'd3;
   localparam logic [4:0] REG_COUNT  = 5'd4;

   // ctrlmode code for the last beat of a message run
   localparam logic [3:0] CTRL_MESSAGE = 4'b1100;

endpackage

// File: hw/dma_top.sv
`timescale 1ns/100ps

module dma_top import dma_pkg::*;
#(
   parameter int          RFAW         = 5,
   parameter logic [31:0] TEST_PATTERN = 32'hc3a5_5a3c,
   parameter int          FIFO_DEPTH   = 4,
   parameter int          MEM_WORDS    = 64
)
(
   input  logic                         clk,
   input  logic                         reset,
   // register port
   input  logic                         mi_en,
   input  logic                         mi_we,
   input  logic [19:0]                  mi_addr,
   input  logic [31:0]                  mi_din,
   output logic [31:0]                  mi_dout,
   // memory read port
   input  logic                         mem_rd_en,
   input  logic [$clog2(MEM_WORDS)-1:0] mem_rd_addr,
   output logic [31:0]                  mem_rd_data,
   output logic                         msg_irq
);

   dma_txn_t eng_txn;     // engine to fifo
   logic     eng_valid;
   logic     eng_ready;
   dma_txn_t fifo_txn;    // fifo to sink
   logic     fifo_valid;
   logic     fifo_ready;

   dma_engine #(
      .RFAW         (RFAW),
      .TEST_PATTERN (TEST_PATTERN)
   ) dma_engine_inst (
      .clk       (clk),
      .reset     (reset),
      .mi_en     (mi_en),
      .mi_we     (mi_we),
      .mi_addr   (mi_addr),
      .mi_din    (mi_din),
      .mi_dout   (mi_dout),
      .eng_txn   (eng_txn),
      .eng_valid (eng_valid),
      .eng_ready (eng_ready)
   );

   txn_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) txn_fifo_inst (
      .clk (clk), .reset (reset),
      .in_txn (eng_txn), .in_valid (eng_valid), .in_ready (eng_ready),
      .out_txn (fifo_txn), .out_valid (fifo_valid), .out_ready (fifo_ready)
   );

   mem_sink #(.MEM_WORDS(MEM_WORDS)) mem_sink_inst (
      .clk (clk), .reset (reset),
      .txn (fifo_txn), .valid (fifo_valid), .ready (fifo_ready),
      .mem_rd_en (mem_rd_en), .mem_rd_addr (mem_rd_addr), .mem_rd_data (mem_rd_data),
      .msg_irq (msg_irq)
   );

endmodule

// File: hw/mem_sink.sv
`timescale 1ns/100ps

module mem_sink import dma_pkg::*;
#(
   parameter int MEM_WORDS = 64  // words of 32 bits
)
(
   input  logic                         clk,
   input  logic                         reset,
   // transaction stream in
   input  dma_txn_t                     txn,
   input  logic                         valid,
   output logic                         ready,
   // host read port
   input  logic                         mem_rd_en,
   input  logic [$clog2(MEM_WORDS)-1:0] mem_rd_addr,  // word index
   output logic [31:0]                  mem_rd_data,
   // message interrupt
   output logic                         msg_irq
);

   localparam int IW = $clog2(MEM_WORDS);

   logic [31:0]   mem [MEM_WORDS];
   logic          wr_beat;
   logic [3:0]    be;        // byte enables
   logic [IW-1:0] wr_idx;

   // host read owns the single port
   assign ready   = ~mem_rd_en;
   assign wr_beat = valid & ready;

   // word index wraps over the memory
   assign wr_idx = IW'(txn.dstaddr[31:2] % MEM_WORDS);

   // ########################################
   // byte enables
   // ########################################
   always_comb
   begin
      case (txn.datamode)
         2'b00:   be = 4'b0001 << txn.dstaddr[1:0];          // byte
         2'b01:   be = 4'b0011 << {txn.dstaddr[1], 1'b0};   // halfword
         default: be = 4'b1111;                             // word and up
      endcase
   end

   // memory cleared on reset so an unwritten word reads 0
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int w = 0; w < MEM_WORDS; w++)
            mem[w] <= '0;
      end
      else if (wr_beat)
      begin
         for (int b = 0; b < 4; b++)
            if (be[b])
               mem[wr_idx][8*b +: 8] <= txn.data[8*b +: 8];  // same lane in and out
      end
   end

   always_ff @(posedge clk)
   begin
      if (mem_rd_en)
         mem_rd_data <= mem[mem_rd_addr];
   end

   // pulse the cycle after a message beat
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         msg_irq <= 1'b0;
      else
         msg_irq <= wr_beat & (txn.ctrlmode == CTRL_MESSAGE);
   end

   // ########################################
   // checks
   // ########################################
   // a beat pending during a host read leaves its target word alone
   a_port_exclusive: assert property (
      @(posedge clk) disable iff (reset)
      mem_rd_en && valid |=> mem[$past(wr_idx)] == $past(mem[wr_idx])
   ) else $error("memory write and host read in same cycle");

endmodule

// File: hw/txn_fifo.sv
`timescale 1ns/100ps

module txn_fifo import dma_pkg::*;
#(
   parameter int FIFO_DEPTH = 4  // power of two, at least 2
)
(
   input  logic     clk,
   input  logic     reset,
   // push side
   input  dma_txn_t in_txn,
   input  logic     in_valid,
   output logic     in_ready,
   // pop side
   output dma_txn_t out_txn,
   output logic     out_valid,
   input  logic     out_ready
);

   localparam int PW = $clog2(FIFO_DEPTH);

   dma_txn_t      mem [FIFO_DEPTH];  // storage, no reset
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [PW:0]   count;             // occupancy 0..FIFO_DEPTH
   logic          push;
   logic          pop;

   assign in_ready  = (count != (PW+1)'(FIFO_DEPTH));  // low only when full
   assign out_valid = (count != '0);
   assign out_txn   = mem[rd_ptr];

   assign push = in_valid & in_ready;
   assign pop  = out_valid & out_ready;

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in_txn;
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + (PW+1)'(push) - (PW+1)'(pop);  // push+pop leaves it as is
      end
   end

   // ########################################
   // checks
   // ########################################
   // occupancy in range and in step with the pointer distance
   a_no_overflow: assert property (
      @(posedge clk) disable iff (reset)
      (count <= (PW+1)'(FIFO_DEPTH)) && ((wr_ptr - rd_ptr) == PW'(count))
   ) else $error("fifo push when full or pop when empty");

   // head entry held while the sink stalls
   a_out_stable: assert property (
      @(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_txn)
   ) else $error("fifo head changed while stalled");

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the dma testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dma -f build.f -o tb_dma_sim

./obj_dir/tb_dma_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
   echo "testbench reported failure, see sim.log"
   exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
   echo "simulation ended without a pass report, see sim.log"
   exit 1
fi

// File: test/tb_dma_tasks.svh
`ifndef TB_DMA_TASKS_SVH
`define TB_DMA_TASKS_SVH

// ########################################
// port access, driven 1 ns after the edge
// ########################################
task reg_write(input logic [4:0] off, input logic [31:0] val);
   @(posedge clk);
   #1;
   mi_en   = 1'b1;
   mi_we   = 1'b1;
   mi_addr = {13'd0, off, 2'b00};  // word offset to byte address
   mi_din  = val;
   @(posedge clk);
   #1;
   mi_en = 1'b0;
   mi_we = 1'b0;
endtask

task reg_read(input logic [4:0] off, output logic [31:0] val);
   @(posedge clk);
   #1;
   mi_en   = 1'b1;
   mi_we   = 1'b0;
   mi_addr = {13'd0, off, 2'b00};
   @(posedge clk);
   #1;
   mi_en = 1'b0;
   val   = mi_dout;  // registered at the edge just passed
endtask

task mem_read(input int idx, output logic [31:0] val);
   @(posedge clk);
   #1;
   mem_rd_en   = 1'b1;
   mem_rd_addr = IW'(idx);
   @(posedge clk);
   #1;
   mem_rd_en = 1'b0;
   val       = mem_rd_data;
endtask

// host reads every other cycle, steals the sink port
task stall_reads();
   int cycles;
   cycles = 0;
   while (!stop_reads)
   begin
      @(posedge clk);
      #1;
      mem_rd_en   = ~mem_rd_en;
      mem_rd_addr = mem_rd_addr + 1'b1;
      cycles++;
      if (cycles > STALL_LIMIT)
         abort_run("timeout: fill under host read stall never completed");
   end
   mem_rd_en = 1'b0;
endtask

// count reaches zero first, the fifo may still hold beats
task wait_done();
   logic [31:0] cnt;
   int          polls;
   int          cycles;
   polls = 0;
   cnt   = 32'hffff_ffff;
   while (cnt != 32'd0)
   begin
      reg_read(REG_COUNT, cnt);
      polls++;
      if (polls > POLL_LIMIT)
         abort_run("timeout: count register never reached zero");
   end
   cycles = 0;
   while (dma_top_inst.fifo_valid)
   begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > DRAIN_LIMIT)
         abort_run("timeout: transaction fifo did not drain");
   end
endtask

// ########################################
// compares
// ########################################
task compare_word(input string what, input logic [31:0] got, input logic [31:0] exp);
   if (got !== exp)
      abort_run($sformatf("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp));
endtask

task compare_cfg(input string what, input dma_cfg_u got, input dma_cfg_u exp);
   if (got.raw !== exp.raw)
      abort_run($sformatf("[FAIL] %0t: %s got %h (en %b mode %0d ctrl %h msg %b) expected %h",
                          $time, what, got.raw, got.f.enable, got.f.datamode,
                          got.f.ctrlmode, got.f.message, exp.raw));
endtask

task check_regs(input logic [31:0] src, input logic [31:0] dst,
                input logic [31:0] count, input logic [31:0] status);
   logic [31:0] got;
   reg_read(REG_SRC, got);
   compare_word("src", got, src);
   reg_read(REG_DST, got);
   compare_word("dst", got, dst);
   reg_read(REG_COUNT, got);
   compare_word("count", got, count);
   reg_read(REG_STATUS, got);
   compare_word("status", got, status);
endtask

task check_memory();
   logic [31:0] got;
   for (int w = 0; w < MEM_WORDS; w++)
   begin
      mem_read(w, got);
      compare_word($sformatf("mem[%0d]", w), got, exp_mem[w]);
   end
endtask

// ########################################
// fill runs and expected image
// ########################################
// every byte address the run covers takes the pattern byte of its lane
task model_fill(input logic [31:0] dst, input logic [1:0] mode, input int n);
   logic [31:0] a;
   int          idx;
   int          lane;
   a = dst;
   for (int i = 0; i < n * (1 << mode); i++)
   begin
      idx  = int'((a >> 2) % MEM_WORDS);
      lane = int'(a[1:0]);
      exp_mem[idx][8*lane +: 8] = TEST_PATTERN[8*lane +: 8];
      a = a + 32'd1;  // next byte
   end
endtask

task start_fill(input logic [31:0] src, input logic [31:0] dst, input logic [1:0] mode,
                input int n, input logic msg);
   reg_write(REG_CFG, cfg_word(1'b0, mode, 4'h3, msg));  // stop and clear status
   reg_write(REG_SRC, src);
   reg_write(REG_DST, dst);
   reg_write(REG_COUNT, n);
   reg_write(REG_CFG, cfg_word(1'b1, mode, 4'h3, msg));
endtask

task verify_fill(input logic [31:0] src, input logic [31:0] dst, input logic [1:0] mode,
                 input int n);
   model_fill(dst, mode, n);
   check_regs(src + (32'(n) << mode), dst + (32'(n) << mode), 32'd0, 32'd0);
   check_memory();
endtask

task run_fill(input logic [31:0] src, input logic [31:0] dst, input logic [1:0] mode,
              input int n, input logic msg);
   start_fill(src, dst, mode, n, msg);
   wait_done();
   verify_fill(src, dst, mode, n);
endtask

`endif

// File: test/tb_dma.sv
`timescale 1ns/100ps

module tb_dma import dma_pkg::*;
();

   localparam logic [31:0] TEST_PATTERN = 32'hc3a5_5a3c;  // same fill as the DUT
   localparam int          MEM_WORDS    = 64;
   localparam int          IW           = $clog2(MEM_WORDS);
   localparam int          POLL_LIMIT   = 100;   // count polls per run
   localparam int          DRAIN_LIMIT  = 64;    // cycles for the fifo to empty
   localparam int          STALL_LIMIT  = 1000;

   logic          clk;
   logic          reset;
   logic          mi_en;
   logic          mi_we;
   logic [19:0]   mi_addr;
   logic [31:0]   mi_din;
   logic [31:0]   mi_dout;
   logic          mem_rd_en;
   logic [IW-1:0] mem_rd_addr;
   logic [31:0]   mem_rd_data;
   logic          msg_irq;

   logic [31:0]   exp_mem [MEM_WORDS];  // expected memory image
   integer        seed = 51781;
   int            irq_count;
   logic          stop_reads;           // ends the host read stall

   dma_top #(
      .TEST_PATTERN (TEST_PATTERN),
      .MEM_WORDS    (MEM_WORDS)
   ) dma_top_inst (
      .clk (clk), .reset (reset),
      .mi_en (mi_en), .mi_we (mi_we), .mi_addr (mi_addr), .mi_din (mi_din), .mi_dout (mi_dout),
      .mem_rd_en (mem_rd_en), .mem_rd_addr (mem_rd_addr), .mem_rd_data (mem_rd_data),
      .msg_irq (msg_irq)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns
   end

   // irq counted mid cycle, pulse is one cycle wide
   always @(negedge clk)
      if (msg_irq)
         irq_count++;

   task abort_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // word aligned source, only advanced by the engine
   function automatic logic [31:0] rand_src();
      return $random(seed) & 32'h0000_fff0;
   endfunction

   function automatic logic [31:0] cfg_word(input logic en, input logic [1:0] mode,
                                            input logic [3:0] ctrl, input logic msg);
      dma_cfg_u c;
      c.raw        = '0;
      c.f.enable   = en;
      c.f.write    = 1'b1;
      c.f.datamode = mode;
      c.f.ctrlmode = ctrl;
      c.f.message  = msg;
      return c.raw;
   endfunction

   `include "tb_dma_tasks.svh"

   // ########################################
   // directed tests
   // ########################################
   task reset_readback();
      logic [31:0] got;
      dma_cfg_u    cfg;
      check_regs(32'd0, 32'd0, 32'd0, 32'd0);
      reg_read(REG_CFG, got);
      compare_word("cfg after reset", got, 32'd0);
      cfg.raw = cfg_word(1'b0, 2'd2, 4'h5, 1'b1);  // enable off, nothing runs
      reg_write(REG_CFG, cfg.raw);
      reg_read(REG_CFG, got);
      compare_cfg("cfg readback", got, cfg);
      reg_write(REG_SRC, 32'h1234_5678);
      reg_write(REG_DST, 32'h9abc_def0);
      reg_write(REG_COUNT, 32'h0000_0031);
      check_regs(32'h1234_5678, 32'h9abc_def0, 32'h0000_0031, 32'd0);
      for (int off = 5; off < 32; off++)
      begin
         reg_read(5'(off), got);
         compare_word("unmapped offset", got, 32'd0);
      end
   endtask

   task back_pressure();
      logic [31:0] src;
      logic [31:0] dst;
      src        = rand_src();
      dst        = 32'(4 * (44 + rand_below(4)));
      stop_reads = 1'b0;
      fork
         begin
            start_fill(src, dst, 2'd2, 12, 1'b0);
            wait_done();
            stop_reads = 1'b1;
         end
         stall_reads();
      join
      verify_fill(src, dst, 2'd2, 12);  // same result as without stalls
   endtask

   task misalign_check();
      logic [31:0] got;
      start_fill(32'h100, 32'h101, 2'd1, 3, 1'b0);  // halfword, odd dst
      check_regs(32'h100, 32'h101, 32'd3, 32'd2);
      start_fill(32'h100, 32'h100, 2'd3, 3, 1'b0);  // double never allowed
      check_regs(32'h100, 32'h100, 32'd3, 32'd2);
      reg_write(REG_CFG, 32'd0);
      reg_read(REG_STATUS, got);
      compare_word("status after cfg write", got, 32'd0);
      check_memory();
   endtask

   task message_irq();
      irq_count = 0;
      run_fill(rand_src(), 32'd240, 2'd2, 4, 1'b1);  // last words of memory
      compare_word("irq pulses with message", 32'(irq_count), 32'd1);
      irq_count = 0;
      run_fill(rand_src(), 32'd0, 2'd2, 2, 1'b0);
      compare_word("irq pulses without message", 32'(irq_count), 32'd0);
   endtask

   // ########################################
   // sequence
   // ########################################
   initial
   begin
      reset       = 1'b1;
      mi_en       = 1'b0;
      mi_we       = 1'b0;
      mi_addr     = '0;
      mi_din      = '0;
      mem_rd_en   = 1'b0;
      mem_rd_addr = '0;
      irq_count   = 0;
      stop_reads  = 1'b0;
      for (int w = 0; w < MEM_WORDS; w++)
         exp_mem[w] = '0;  // sink clears on reset
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;
      reset_readback();
      run_fill(rand_src(), 32'(4 * (2 + rand_below(16))), 2'd2, 8, 1'b0);   // word fill
      run_fill(rand_src(), 32'(4 * (28 + rand_below(4)) + 1), 2'd0, 7, 1'b0);  // odd byte
      run_fill(rand_src(), 32'(4 * (36 + rand_below(4)) + 2), 2'd1, 5, 1'b0);  // halfword
      back_pressure();
      misalign_check();
      message_irq();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule
